// File: mips_isa_pkg.sv
package mips_isa_pkg;

    // instruction field positions
    localparam int OPCODE_LSB = 26;
    localparam int OPCODE_W   = 6;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_LSB  = 6;
    localparam int SHAMT_W    = 5;
    localparam int FUNCT_LSB  = 0;
    localparam int FUNCT_W    = 6;
    localparam int IMM16_LSB  = 0;
    localparam int IMM16_W    = 16;

    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [OPCODE_W-1:0] {
        SPECIAL = 6'h00,
        ADDIU   = 6'h09,
        SLTI    = 6'h0a,
        ANDI    = 6'h0c,
        ORI     = 6'h0d,
        XORI    = 6'h0e,
        LUI     = 6'h0f
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [FUNCT_W-1:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        SRA  = 6'h03,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a,
        SLTU = 6'h2b
    } funct_e;

endpackage

// File: mips_pipe_pkg.sv
package mips_pipe_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // boot vector of the kseg1 rom
    localparam word_t RESET_PC = 32'hbfc0_0000;
    localparam word_t PC_STEP  = 32'd4;

    // cycles from an accepted fetch to the debug trace
    localparam int WB_LATENCY  = 3;
    localparam int WB_WEN_BITS = 4;

    // register shifts share the immediate shift ops
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

endpackage

// File: pipe_ifs.sv
`timescale 1ns/1ps

// decode to execute
interface exec_bus_if;
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic               valid;
    word_t              pc;
    alu_op_e            alu_op;
    word_t              operand_a;
    word_t              operand_b;
    logic [SHAMT_W-1:0] shamt;
    logic               write_en;
    reg_addr_t          write_addr;

    modport decode (
        output valid, pc, alu_op, operand_a, operand_b, shamt, write_en, write_addr
    );

    modport alu (
        input valid, pc, alu_op, operand_a, operand_b, shamt, write_en, write_addr
    );
endinterface

// a result heading for the register file
interface result_bus_if;
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic      valid;
    word_t     pc;
    logic      write_en;
    reg_addr_t write_addr;
    word_t     write_data;

    modport source (output valid, pc, write_en, write_addr, write_data);
    modport sink (input valid, pc, write_en, write_addr, write_data);
    // forwarding taps in decode
    modport monitor (input valid, pc, write_en, write_addr, write_data);
endinterface

// File: mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch (
    input  logic                 clock_i,
    input  logic                 rst_n_i,
    input  logic                 inst_stall_i,
    input  mips_pipe_pkg::word_t inst_sram_rdata_i,
    output mips_pipe_pkg::word_t inst_sram_addr_o,
    output logic                 fetch_valid_o,
    output mips_pipe_pkg::word_t fetch_pc_o,
    output mips_pipe_pkg::word_t fetch_inst_o
);
    import mips_pipe_pkg::*;

    word_t pc_q;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!inst_stall_i) begin
            pc_q <= pc_q + PC_STEP;
        end
    end

    // sram answers in the same cycle
    assign inst_sram_addr_o = pc_q;

    // a stalled cycle enters decode as a bubble
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= !inst_stall_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!inst_stall_i) begin
            fetch_pc_o   <= pc_q;
            fetch_inst_o <= inst_sram_rdata_i;
        end
    end

    // held address, and nothing handed to decode
    a_stall_holds_pc: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        inst_stall_i |=> $stable(inst_sram_addr_o) && !fetch_valid_o
    ) else $error("fetch moved on during a stall");

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic                    clock_i,
    input  logic                    rst_n_i,
    input  mips_isa_pkg::reg_addr_t rs_addr_i,
    input  mips_isa_pkg::reg_addr_t rt_addr_i,
    output mips_pipe_pkg::word_t    rs_data_o,
    output mips_pipe_pkg::word_t    rt_data_o,
    result_bus_if.sink              wb
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t regs_q [REG_COUNT];

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb.valid && wb.write_en) begin
            regs_q[wb.write_addr] <= wb.write_data;
        end
    end

    // $zero is hardwired
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs_q[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs_q[rt_addr_i];

    // decode drops the write enable for $zero
    a_no_zero_write: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        (wb.valid && wb.write_en) |-> (wb.write_addr != '0)
    ) else $error("register file write to $zero");

endmodule

// File: mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
    input  logic                    clock_i,
    input  logic                    rst_n_i,
    input  logic                    fetch_valid_i,
    input  mips_pipe_pkg::word_t    fetch_pc_i,
    input  mips_pipe_pkg::word_t    fetch_inst_i,
    output mips_isa_pkg::reg_addr_t rs_addr_o,
    output mips_isa_pkg::reg_addr_t rt_addr_o,
    input  mips_pipe_pkg::word_t    rs_data_i,
    input  mips_pipe_pkg::word_t    rt_data_i,
    result_bus_if.monitor           ex_res,
    result_bus_if.monitor           wb_res,
    exec_bus_if.decode              exec
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    opcode_e              opcode;
    funct_e               funct;
    reg_addr_t            rd_addr;
    reg_addr_t            dest;
    logic [IMM16_W-1:0]   imm16;
    word_t                imm_sext;
    word_t                imm_zext;
    word_t                imm_upper;
    word_t                imm_ext;
    word_t                rs_val;
    word_t                rt_val;
    alu_op_e              alu_op_d;
    logic                 known;
    logic                 write_en_d;

    assign opcode    = opcode_e'(fetch_inst_i[OPCODE_LSB +: OPCODE_W]);
    assign funct     = funct_e'(fetch_inst_i[FUNCT_LSB +: FUNCT_W]);
    assign rs_addr_o = fetch_inst_i[RS_LSB +: REG_ADDR_W];
    assign rt_addr_o = fetch_inst_i[RT_LSB +: REG_ADDR_W];
    assign rd_addr   = fetch_inst_i[RD_LSB +: REG_ADDR_W];
    assign imm16     = fetch_inst_i[IMM16_LSB +: IMM16_W];

    assign imm_sext  = {{(XLEN-IMM16_W){imm16[IMM16_W-1]}}, imm16};
    assign imm_zext  = {{(XLEN-IMM16_W){1'b0}}, imm16};
    assign imm_upper = {imm16, {(XLEN-IMM16_W){1'b0}}};

    // execute result is one slot newer than writeback
    assign rs_val = (ex_res.valid && ex_res.write_en && ex_res.write_addr == rs_addr_o) ?
                    ex_res.write_data :
                    (wb_res.valid && wb_res.write_en && wb_res.write_addr == rs_addr_o) ?
                    wb_res.write_data : rs_data_i;
    assign rt_val = (ex_res.valid && ex_res.write_en && ex_res.write_addr == rt_addr_o) ?
                    ex_res.write_data :
                    (wb_res.valid && wb_res.write_en && wb_res.write_addr == rt_addr_o) ?
                    wb_res.write_data : rt_data_i;

    always_comb begin
        alu_op_d = ALU_ADD;
        imm_ext  = imm_sext;
        known    = 1'b1;
        case (opcode)
            SPECIAL: begin
                case (funct)
                    SLL:     alu_op_d = ALU_SLL;
                    SRL:     alu_op_d = ALU_SRL;
                    SRA:     alu_op_d = ALU_SRA;
                    ADDU:    alu_op_d = ALU_ADD;
                    SUBU:    alu_op_d = ALU_SUB;
                    AND:     alu_op_d = ALU_AND;
                    OR:      alu_op_d = ALU_OR;
                    XOR:     alu_op_d = ALU_XOR;
                    NOR:     alu_op_d = ALU_NOR;
                    SLT:     alu_op_d = ALU_SLT;
                    SLTU:    alu_op_d = ALU_SLTU;
                    default: known = 1'b0;
                endcase
            end
            ADDIU:   alu_op_d = ALU_ADD;
            SLTI:    alu_op_d = ALU_SLT;
            ANDI: begin
                alu_op_d = ALU_AND;
                imm_ext  = imm_zext;
            end
            ORI: begin
                alu_op_d = ALU_OR;
                imm_ext  = imm_zext;
            end
            XORI: begin
                alu_op_d = ALU_XOR;
                imm_ext  = imm_zext;
            end
            LUI: begin
                alu_op_d = ALU_LUI;
                imm_ext  = imm_upper;
            end
            default: known = 1'b0;
        endcase
    end

    // i-type writes rt
    assign dest       = (opcode == SPECIAL) ? rd_addr : rt_addr_o;
    assign write_en_d = fetch_valid_i && known && (dest != '0);

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            exec.valid    <= 1'b0;
            exec.write_en <= 1'b0;
        end else begin
            exec.valid    <= fetch_valid_i && known;
            exec.write_en <= write_en_d;
        end
    end

    always_ff @(posedge clock_i) begin
        exec.pc         <= fetch_pc_i;
        exec.alu_op     <= alu_op_d;
        exec.operand_a  <= rs_val;
        exec.operand_b  <= (opcode == SPECIAL) ? rt_val : imm_ext;
        exec.shamt      <= fetch_inst_i[SHAMT_LSB +: SHAMT_W];
        exec.write_addr <= dest;
    end

endmodule

// File: mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    exec_bus_if.alu      exec,
    result_bus_if.source ex_res
);
    import mips_pipe_pkg::*;

    word_t result;

    always_comb begin
        case (exec.alu_op)
            ALU_ADD:  result = exec.operand_a + exec.operand_b;
            ALU_SUB:  result = exec.operand_a - exec.operand_b;
            ALU_AND:  result = exec.operand_a & exec.operand_b;
            ALU_OR:   result = exec.operand_a | exec.operand_b;
            ALU_XOR:  result = exec.operand_a ^ exec.operand_b;
            ALU_NOR:  result = ~(exec.operand_a | exec.operand_b);
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}},
                          $signed(exec.operand_a) < $signed(exec.operand_b)};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, exec.operand_a < exec.operand_b};
            end
            // shifts act on rt by the decoded shamt
            ALU_SLL:  result = exec.operand_b << exec.shamt;
            ALU_SRL:  result = exec.operand_b >> exec.shamt;
            ALU_SRA:  result = $signed(exec.operand_b) >>> exec.shamt;
            ALU_LUI:  result = exec.operand_b;
            default:  result = '0;
        endcase
    end

    assign ex_res.valid      = exec.valid;
    assign ex_res.pc         = exec.pc;
    assign ex_res.write_en   = exec.write_en;
    assign ex_res.write_addr = exec.write_addr;
    assign ex_res.write_data = result;

    // decode only issues mapped operations
    a_alu_op_known: assert final (
        exec.valid !== 1'b1 || (!$isunknown(exec.alu_op) && exec.alu_op <= ALU_LUI)
    ) else $error("unmapped alu_op %0h issued", exec.alu_op);

endmodule

// File: mips_writeback.sv
`timescale 1ns/1ps

module mips_writeback (
    input  logic                                  clock_i,
    input  logic                                  rst_n_i,
    result_bus_if.sink                            ex_res,
    result_bus_if.source                          wb_res,
    output mips_pipe_pkg::word_t                  debug_wb_pc_o,
    output logic [mips_pipe_pkg::WB_WEN_BITS-1:0] debug_wb_wen_o,
    output mips_isa_pkg::reg_addr_t               debug_wb_num_o,
    output mips_pipe_pkg::word_t                  debug_wb_data_o
);
    import mips_pipe_pkg::*;

    // execute result held for the trace and the register file
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            wb_res.valid      <= 1'b0;
            wb_res.pc         <= '0;
            wb_res.write_en   <= 1'b0;
            wb_res.write_addr <= '0;
            wb_res.write_data <= '0;
        end else begin
            wb_res.valid      <= ex_res.valid;
            wb_res.pc         <= ex_res.pc;
            wb_res.write_en   <= ex_res.write_en;
            wb_res.write_addr <= ex_res.write_addr;
            wb_res.write_data <= ex_res.write_data;
        end
    end

    // all byte lanes or none
    assign debug_wb_wen_o  = {WB_WEN_BITS{wb_res.valid && wb_res.write_en}};
    assign debug_wb_num_o  = wb_res.write_addr;
    assign debug_wb_data_o = wb_res.write_data;
    assign debug_wb_pc_o   = wb_res.pc;

endmodule

// File: mips_top.sv
`timescale 1ns/1ps

module mips_top (
    input  logic                                  clock_i,
    input  logic                                  rst_n_i,
    output mips_pipe_pkg::word_t                  inst_sram_addr_o,
    input  mips_pipe_pkg::word_t                  inst_sram_rdata_i,
    input  logic                                  inst_stall_i,
    output mips_pipe_pkg::word_t                  debug_wb_pc_o,
    output logic [mips_pipe_pkg::WB_WEN_BITS-1:0] debug_wb_wen_o,
    output mips_isa_pkg::reg_addr_t               debug_wb_num_o,
    output mips_pipe_pkg::word_t                  debug_wb_data_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic      fetch_valid;
    word_t     fetch_pc;
    word_t     fetch_inst;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    exec_bus_if   exec ();
    // ex_res feeds writeback, wb_res feeds the register file
    result_bus_if ex_res ();
    result_bus_if wb_res ();

    mips_fetch i_fetch (
        .clock_i          (clock_i),
        .rst_n_i          (rst_n_i),
        .inst_stall_i     (inst_stall_i),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .inst_sram_addr_o (inst_sram_addr_o),
        .fetch_valid_o    (fetch_valid),
        .fetch_pc_o       (fetch_pc),
        .fetch_inst_o     (fetch_inst)
    );

    mips_decode i_decode (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .fetch_valid_i(fetch_valid),
        .fetch_pc_i   (fetch_pc),
        .fetch_inst_i (fetch_inst),
        .rs_addr_o    (rs_addr),
        .rt_addr_o    (rt_addr),
        .rs_data_i    (rs_data),
        .rt_data_i    (rt_data),
        .ex_res       (ex_res),
        .wb_res       (wb_res),
        .exec         (exec)
    );

    mips_regfile i_regfile (
        .clock_i  (clock_i),
        .rst_n_i  (rst_n_i),
        .rs_addr_i(rs_addr),
        .rt_addr_i(rt_addr),
        .rs_data_o(rs_data),
        .rt_data_o(rt_data),
        .wb       (wb_res)
    );

    mips_alu i_alu (
        .exec  (exec),
        .ex_res(ex_res)
    );

    mips_writeback i_writeback (
        .clock_i        (clock_i),
        .rst_n_i        (rst_n_i),
        .ex_res         (ex_res),
        .wb_res         (wb_res),
        .debug_wb_pc_o  (debug_wb_pc_o),
        .debug_wb_wen_o (debug_wb_wen_o),
        .debug_wb_num_o (debug_wb_num_o),
        .debug_wb_data_o(debug_wb_data_o)
    );

endmodule

// File: tb_mips_top.sv
`timescale 1ns/1ps

module tb_mips_top;
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    localparam int    PROG_LEN       = 200;
    localparam int    TIMEOUT_CYCLES = 4 * PROG_LEN + 50;
    localparam int    SEED           = 41856;
    localparam word_t PROG_END       = RESET_PC + PROG_LEN * PC_STEP;

    typedef struct packed {
        word_t     pc;
        reg_addr_t num;
        word_t     data;
    } trace_t;

    logic                   clock_i;
    logic                   rst_n_i;
    word_t                  inst_sram_addr_o;
    word_t                  inst_sram_rdata_i;
    logic                   inst_stall_i;
    word_t                  debug_wb_pc_o;
    logic [WB_WEN_BITS-1:0] debug_wb_wen_o;
    reg_addr_t              debug_wb_num_o;
    word_t                  debug_wb_data_o;

    word_t  rom [PROG_LEN];
    word_t  rom_index;
    trace_t exp_q [$];
    trace_t head;
    logic   head_ok;
    logic   fetch_writes;
    logic   done;
    int     cycles;
    int     value_errors;
    int     other_errors;

    mips_top i_dut (
        .clock_i          (clock_i),
        .rst_n_i          (rst_n_i),
        .inst_sram_addr_o (inst_sram_addr_o),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .inst_stall_i     (inst_stall_i),
        .debug_wb_pc_o    (debug_wb_pc_o),
        .debug_wb_wen_o   (debug_wb_wen_o),
        .debug_wb_num_o   (debug_wb_num_o),
        .debug_wb_data_o  (debug_wb_data_o)
    );

    always #20 clock_i = ~clock_i;

    // true when the word writes a nonzero register
    function automatic logic writes_reg(word_t inst);
        logic [OPCODE_W-1:0] op;
        logic [FUNCT_W-1:0]  fn;
        op = inst[OPCODE_LSB +: OPCODE_W];
        fn = inst[FUNCT_LSB +: FUNCT_W];
        case (op)
            SPECIAL: begin
                return (fn inside {SLL, SRL, SRA, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU})
                       && (inst[RD_LSB +: REG_ADDR_W] != '0);
            end
            ADDIU, SLTI, ANDI, ORI, XORI, LUI: return inst[RT_LSB +: REG_ADDR_W] != '0;
            default: return 1'b0;
        endcase
    endfunction

    // a is the rs value, b the rt value
    function automatic word_t expected_result(word_t inst, word_t a, word_t b);
        logic [OPCODE_W-1:0] op;
        logic [SHAMT_W-1:0]  sa;
        logic [IMM16_W-1:0]  imm;
        word_t               sext;
        word_t               zext;
        op   = inst[OPCODE_LSB +: OPCODE_W];
        sa   = inst[SHAMT_LSB +: SHAMT_W];
        imm  = inst[IMM16_LSB +: IMM16_W];
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (op)
            ADDIU:   return a + sext;
            SLTI:    return word_t'($signed(a) < $signed(sext));
            ANDI:    return a & zext;
            ORI:     return a | zext;
            XORI:    return a ^ zext;
            LUI:     return {imm, 16'h0000};
            default: ;
        endcase
        case (inst[FUNCT_LSB +: FUNCT_W])
            SLL:     return b << sa;
            SRL:     return b >> sa;
            SRA:     return word_t'($signed(b) >>> sa);
            ADDU:    return a + b;
            SUBU:    return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            NOR:     return ~(a | b);
            SLT:     return word_t'($signed(a) < $signed(b));
            SLTU:    return word_t'(a < b);
            default: return '0;
        endcase
    endfunction

    // small pool keeps dependencies dense with $zero now and then
    function automatic reg_addr_t pick_reg();
        if ($urandom % 8 == 0) begin
            return '0;
        end
        return reg_addr_t'(1 + $urandom % 5);
    endfunction

    task automatic build_program();
        funct_e    r_funct [11] = '{SLL, SRL, SRA, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU};
        opcode_e   i_ops [6]    = '{ADDIU, SLTI, ANDI, ORI, XORI, LUI};
        word_t     model_regs [REG_COUNT];
        word_t     inst;
        word_t     res;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        reg_addr_t dest;
        int        kind;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rs   = pick_reg();
            rt   = pick_reg();
            rd   = pick_reg();
            kind = $urandom % 20;
            if (kind < 11) begin
                inst = {6'h00, rs, rt, rd, 5'($urandom), r_funct[kind]};
            end else if (kind < 17) begin
                inst = {i_ops[kind-11], rs, rt, 16'($urandom)};
            end else if (kind == 17) begin
                // loads are dropped from this core
                inst = {6'h23, rs, rt, 16'($urandom)};
            end else if (kind == 18) begin
                // mfhi is unsupported too
                inst = {6'h00, rs, rt, rd, 5'd0, 6'h10};
            end else begin
                inst = {ADDIU, rs, rt, 16'($urandom)};
            end
            rom[i] = inst;
            if (writes_reg(inst)) begin
                res  = expected_result(inst, model_regs[rs], model_regs[rt]);
                dest = (inst[OPCODE_LSB +: OPCODE_W] == SPECIAL) ? rd : rt;
                model_regs[dest] = res;
                exp_q.push_back('{pc: RESET_PC + PC_STEP * i, num: dest, data: res});
            end
        end
    endtask

    // instruction sram that reads zero past the end of the program
    always_comb begin
        rom_index = (inst_sram_addr_o - RESET_PC) / PC_STEP;
        if (rom_index < PROG_LEN) begin
            inst_sram_rdata_i = rom[rom_index];
        end else begin
            inst_sram_rdata_i = '0;
        end
    end

    always_comb begin
        fetch_writes = writes_reg(inst_sram_rdata_i);
    end

    // expected entry for the trace of the current cycle
    always @(posedge clock_i) begin
        if (rst_n_i && debug_wb_wen_o != '0 && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        head_ok <= exp_q.size() > 0;
        if (exp_q.size() > 0) begin
            head <= exp_q[0];
        end
    end

    always @(posedge clock_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: program did not drain within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    a_reset_wen: assert property (
        @(posedge clock_i) !rst_n_i |=> debug_wb_wen_o == '0
    ) else begin
        value_errors++;
        $display("ERROR debug_wb_wen_o expected %01h actual %01h", 0, $sampled(debug_wb_wen_o));
    end

    a_reset_addr: assert property (
        @(posedge clock_i) !rst_n_i |=> inst_sram_addr_o == RESET_PC
    ) else begin
        value_errors++;
        $display("ERROR inst_sram_addr_o expected %08h actual %08h",
                 RESET_PC, $sampled(inst_sram_addr_o));
    end

    a_stall_holds_addr: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        (rst_n_i && inst_stall_i) |=> $stable(inst_sram_addr_o)
    ) else begin
        other_errors++;
        $display("fetch address moved while inst_stall_i was high");
    end

    // the first cycle out of reset is not an accepted fetch
    a_write_latency: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        (rst_n_i && !inst_stall_i && fetch_writes) |-> ##WB_LATENCY (debug_wb_wen_o == '1)
    ) else begin
        other_errors++;
        $display("accepted write did not reach the trace %0d cycles later", WB_LATENCY);
    end

    a_no_stray_trace: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        (rst_n_i && (inst_stall_i || !fetch_writes)) |-> ##WB_LATENCY (debug_wb_wen_o == '0)
    ) else begin
        other_errors++;
        $display("trace entry without a writing instruction behind it");
    end

    a_trace_expected: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        (debug_wb_wen_o != '0) |-> head_ok
    ) else begin
        other_errors++;
        $display("trace entry after all expected entries were seen");
    end

    a_trace_pc: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        (debug_wb_wen_o != '0 && head_ok) |-> debug_wb_pc_o == head.pc
    ) else begin
        value_errors++;
        $display("ERROR debug_wb_pc_o expected %08h actual %08h",
                 $sampled(head.pc), $sampled(debug_wb_pc_o));
    end

    a_trace_num: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        (debug_wb_wen_o != '0 && head_ok) |-> debug_wb_num_o == head.num
    ) else begin
        value_errors++;
        $display("ERROR debug_wb_num_o expected %02h actual %02h",
                 $sampled(head.num), $sampled(debug_wb_num_o));
    end

    a_trace_data: assert property (
        @(posedge clock_i) disable iff (!rst_n_i)
        (debug_wb_wen_o != '0 && head_ok) |-> debug_wb_data_o == head.data
    ) else begin
        value_errors++;
        $display("ERROR debug_wb_data_o expected %08h actual %08h",
                 $sampled(head.data), $sampled(debug_wb_data_o));
    end

    initial begin
        clock_i      = 1'b0;
        rst_n_i      = 1'b0;
        inst_stall_i = 1'b0;
        head_ok      = 1'b0;
        done         = 1'b0;
        cycles       = 0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(SEED));
        build_program();
        repeat (2) @(posedge clock_i);
        rst_n_i <= 1'b1;
        while (!done) begin
            @(posedge clock_i);
            inst_stall_i <= ($urandom % 4) == 0;
            @(negedge clock_i);
            done = (inst_sram_addr_o >= PROG_END) && (exp_q.size() == 0);
        end
        // let the last fetches reach the trace
        repeat (WB_LATENCY + 1) @(posedge clock_i);
        @(negedge clock_i);
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
mips_isa_pkg.sv
mips_pipe_pkg.sv
pipe_ifs.sv
mips_fetch.sv
mips_regfile.sv
mips_decode.sv
mips_alu.sv
mips_writeback.sv
mips_top.sv
tb_mips_top.sv

// File: Bender.yml
package:
  name: mips_pipe

sources:
  - files:
      - mips_isa_pkg.sv
      - mips_pipe_pkg.sv
      - pipe_ifs.sv
      - mips_fetch.sv
      - mips_regfile.sv
      - mips_decode.sv
      - mips_alu.sv
      - mips_writeback.sv
      - mips_top.sv
  - target: test
    files:
      - tb_mips_top.sv
